//--- logic/pe_pkg.sv
package pe_pkg;

    ////////////////////
    // data format
    ////////////////////

    // width of one real or imaginary part
    localparam int part_width = 16;

    // real part in the upper half, imaginary in the lower half
    typedef struct packed {
        logic signed [part_width-1:0] re;
        logic signed [part_width-1:0] im;
    } cmplx_t;

    ////////////////////
    // instruction format
    ////////////////////

    typedef struct packed {
        logic [7:0] opcode;
        logic [7:0] src_b;
        logic [7:0] src_a;
        logic [7:0] dest;
    } inst_t;

    // dest bit set -> result goes to the shared memory
    localparam int mem_flag = 7;

    localparam logic [7:0] op_cmul      = 8'h60;
    // a times conjugate of b
    localparam logic [7:0] op_cmul_conj = 8'h61;

    // default sizes, overridden from the cluster top
    localparam int def_reg_depth   = 16;
    localparam int def_queue_depth = 8;
    localparam int def_res_depth   = 16;
    localparam int def_num_pe      = 2;

endpackage

//--- logic/cmplx_mult.sv
`timescale 1ns/1ps

module cmplx_mult (
    input  logic           clk,
    input  logic           reset,
    input  logic           in_v,
    input  pe_pkg::cmplx_t a,
    input  pe_pkg::cmplx_t b,
    input  logic           conj,
    input  logic [7:0]     dest,
    input  logic           stall,
    output logic           out_v,
    output logic [7:0]     out_dest,
    output pe_pkg::cmplx_t prod
);
    import pe_pkg::*;

    // b imaginary part, flipped for the conjugate form
    logic signed [part_width-1:0]   b_im;
    logic signed [2*part_width-1:0] m_rr;
    logic signed [2*part_width-1:0] m_ii;
    logic signed [2*part_width-1:0] m_ri;
    logic signed [2*part_width-1:0] m_ir;

    // stage one registers, only the low half survives the wrap
    logic                  s1_v;
    logic [7:0]            s1_dest;
    logic [part_width-1:0] p_rr;
    logic [part_width-1:0] p_ii;
    logic [part_width-1:0] p_ri;
    logic [part_width-1:0] p_ir;

    assign b_im = conj ? -b.im : b.im;

    // four partial products
    assign m_rr = a.re * b.re;
    assign m_ii = a.im * b_im;
    assign m_ri = a.re * b_im;
    assign m_ir = a.im * b.re;

    // valid bits, frozen on stall
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_v  <= 1'b0;
            out_v <= 1'b0;
        end else if (!stall) begin
            s1_v  <= in_v;
            out_v <= s1_v;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_dest  <= dest;
            p_rr     <= m_rr[part_width-1:0];
            p_ii     <= m_ii[part_width-1:0];
            p_ri     <= m_ri[part_width-1:0];
            p_ir     <= m_ir[part_width-1:0];
            // stage two, 16-bit wrapping add and subtract
            out_dest <= s1_dest;
            prod.re  <= p_rr - p_ii;
            prod.im  <= p_ri + p_ir;
        end
    end

endmodule

//--- logic/pe.sv
`timescale 1ns/1ps

module pe #(
    parameter int reg_depth   = pe_pkg::def_reg_depth,
    parameter int queue_depth = pe_pkg::def_queue_depth
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           din_v,
    input  pe_pkg::cmplx_t din_pe,
    input  logic           inst_in_v,
    input  pe_pkg::inst_t  inst_in,
    output logic           dout_fwd_v,
    output pe_pkg::cmplx_t dout_fwd,
    output logic           req,
    input  logic           gnt,
    output logic [7:0]     res_addr,
    output pe_pkg::cmplx_t res_data
);
    import pe_pkg::*;

    // register index taken from the low source bits of a power-of-two depth
    localparam int raw = $clog2(reg_depth);
    localparam int wpw = $clog2(reg_depth + 1);
    localparam int qaw = $clog2(queue_depth);
    localparam int qcw = $clog2(queue_depth + 1);

    cmplx_t           reg_file [reg_depth];
    logic [reg_depth-1:0] reg_vld;
    logic [wpw-1:0]   wp;

    inst_t            q_mem [queue_depth];
    logic [qaw-1:0]   q_head;
    logic [qaw-1:0]   q_tail;
    logic [qcw-1:0]   q_cnt;
    logic             q_full;
    logic             q_empty;
    logic             push;
    logic             pop;
    inst_t            head;

    logic             a_rdy;
    logic             b_rdy;
    logic             known_op;
    logic             issue;
    logic             stall;
    logic             m_v;
    logic [7:0]       m_dest;
    cmplx_t           m_prod;
    logic             wb_en;
    logic             slot_load;
    logic             slot_full;

    ////////////////////
    // operand stream
    ////////////////////

    // one cycle late toward the neighbour
    always_ff @(posedge clk) begin
        if (reset) begin
            dout_fwd_v <= 1'b0;
        end else begin
            dout_fwd_v <= din_v;
        end
    end

    always_ff @(posedge clk) begin
        dout_fwd <= din_pe;
        if (din_v && int'(wp) < reg_depth) begin
            reg_file[wp[raw-1:0]] <= din_pe;
        end
        // write-back lands after the stream write
        if (wb_en) begin
            reg_file[m_dest[raw-1:0]] <= m_prod;
        end
    end

    // presence bits set by stream or write-back and cleared while a write-back is pending
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_vld <= '0;
            wp      <= '0;
        end else begin
            if (din_v && int'(wp) < reg_depth) begin
                reg_vld[wp[raw-1:0]] <= 1'b1;
                wp <= wp + 1'b1;
            end
            if (wb_en) begin
                reg_vld[m_dest[raw-1:0]] <= 1'b1;
            end
            if (issue && !head.dest[mem_flag]) begin
                reg_vld[head.dest[raw-1:0]] <= 1'b0;
            end
        end
    end

    ////////////////////
    // instruction queue
    ////////////////////

    assign q_full  = int'(q_cnt) == queue_depth;
    assign q_empty = q_cnt == '0;
    assign push    = inst_in_v && !q_full;
    assign head    = q_mem[q_head];

    always_ff @(posedge clk) begin
        if (push) begin
            q_mem[q_tail] <= inst_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            q_head <= '0;
            q_tail <= '0;
            q_cnt  <= '0;
        end else begin
            if (push) begin
                q_tail <= (int'(q_tail) == queue_depth - 1) ? '0 : q_tail + 1'b1;
            end
            if (pop) begin
                q_head <= (int'(q_head) == queue_depth - 1) ? '0 : q_head + 1'b1;
            end
            q_cnt <= q_cnt + qcw'(push) - qcw'(pop);
        end
    end

    ////////////////////
    // issue
    ////////////////////

    assign known_op = head.opcode == op_cmul || head.opcode == op_cmul_conj;
    assign a_rdy    = int'(head.src_a) < reg_depth && reg_vld[head.src_a[raw-1:0]];
    assign b_rdy    = int'(head.src_b) < reg_depth && reg_vld[head.src_b[raw-1:0]];
    // full slot without grant freezes the pipe
    assign stall    = slot_full && !gnt;
    assign issue    = !q_empty && known_op && a_rdy && b_rdy && !stall;
    // unknown opcodes are dropped at the head
    assign pop      = issue || (!q_empty && !known_op);

    cmplx_mult u_mult (
        .clk      (clk),
        .reset    (reset),
        .in_v     (issue),
        .a        (reg_file[head.src_a[raw-1:0]]),
        .b        (reg_file[head.src_b[raw-1:0]]),
        .conj     (head.opcode == op_cmul_conj),
        .dest     (head.dest),
        .stall    (stall),
        .out_v    (m_v),
        .out_dest (m_dest),
        .prod     (m_prod)
    );

    ////////////////////
    // result slot
    ////////////////////

    assign wb_en     = m_v && !stall && !m_dest[mem_flag];
    assign slot_load = m_v && !stall && m_dest[mem_flag];
    assign req       = slot_full;

    // refill on the grant edge keeps the slot busy
    always_ff @(posedge clk) begin
        if (reset) begin
            slot_full <= 1'b0;
        end else if (slot_load) begin
            slot_full <= 1'b1;
        end else if (gnt) begin
            slot_full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (slot_load) begin
            res_addr <= {1'b0, m_dest[6:0]};
            res_data <= m_prod;
        end
    end

    // instruction overflow has no back-pressure
    assert property (@(posedge clk) disable iff (reset) inst_in_v |-> !q_full);
    // request and payload held until the arbiter takes them
    assert property (@(posedge clk) disable iff (reset)
        req && !gnt |=> req && $stable(res_addr) && $stable(res_data));

endmodule

//--- logic/result_arbiter.sv
`timescale 1ns/1ps

module result_arbiter #(
    parameter int num_pe = pe_pkg::def_num_pe
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [num_pe-1:0]             req,
    input  logic [num_pe-1:0][7:0]        addr_in,
    input  pe_pkg::cmplx_t [num_pe-1:0]   data_in,
    output logic [num_pe-1:0]             gnt,
    output logic                          wr_en,
    output logic [7:0]                    wr_addr,
    output pe_pkg::cmplx_t                wr_data
);

    localparam int pw = num_pe > 1 ? $clog2(num_pe) : 1;

    // first requester to look at
    logic [pw-1:0] ptr;
    logic [pw-1:0] win;
    logic          found;

    // scan from ptr with wraparound
    always_comb begin
        int idx;
        found = 1'b0;
        win   = '0;
        for (int i = 0; i < num_pe; i++) begin
            idx = (int'(ptr) + i) % num_pe;
            if (!found && req[idx]) begin
                found = 1'b1;
                win   = pw'(idx);
            end
        end
        gnt      = '0;
        gnt[win] = found;
    end

    // write bus in the grant cycle
    assign wr_en   = found;
    assign wr_addr = addr_in[win];
    assign wr_data = data_in[win];

    // pointer skips past the winner
    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (found) begin
            ptr <= (int'(win) == num_pe - 1) ? '0 : win + 1'b1;
        end
    end

    // a winner yields to any other requester on the next cycle
    assert property (@(posedge clk) disable iff (reset)
        found |=> (req & ~$past(gnt)) == '0 || (gnt & $past(gnt)) == '0);

endmodule

//--- logic/result_mem.sv
`timescale 1ns/1ps

module result_mem #(
    parameter int res_depth = pe_pkg::def_res_depth
) (
    input  logic           clk,
    input  logic           wr_en,
    input  logic [7:0]     wr_addr,
    input  pe_pkg::cmplx_t wr_data,
    input  logic [7:0]     rd_addr,
    output pe_pkg::cmplx_t rd_data
);
    import pe_pkg::*;

    localparam int aw = $clog2(res_depth);

    cmplx_t mem [res_depth];

    // single write port, read registered one cycle
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr[aw-1:0]] <= wr_data;
        end
        rd_data <= mem[rd_addr[aw-1:0]];
    end

    // dest fields from the instruction streams must fit the memory
    assert property (@(posedge clk) wr_en |-> int'(wr_addr) < res_depth);

endmodule

//--- logic/pe_cluster.sv
`timescale 1ns/1ps

module pe_cluster #(
    parameter int reg_depth   = pe_pkg::def_reg_depth,
    parameter int queue_depth = pe_pkg::def_queue_depth,
    parameter int res_depth   = pe_pkg::def_res_depth
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 din_v,
    input  pe_pkg::cmplx_t       din_pe,
    input  logic [1:0]           inst_in_v,
    input  pe_pkg::inst_t [1:0]  inst_in,
    output logic                 res_v,
    output logic [7:0]           res_addr,
    output pe_pkg::cmplx_t       res_data,
    input  logic [7:0]           rd_addr,
    output pe_pkg::cmplx_t       rd_data
);
    import pe_pkg::*;

    // two elements instantiated below
    localparam int num_pe = 2;

    // operand stream between the elements
    logic                  fwd_v;
    cmplx_t                fwd;

    // result bus, one lane per element
    logic [num_pe-1:0]      req;
    logic [num_pe-1:0]      gnt;
    logic [num_pe-1:0][7:0] addr;
    cmplx_t [num_pe-1:0]    data;

    ////////////////////
    // processing elements
    ////////////////////

    pe #(
        .reg_depth   (reg_depth),
        .queue_depth (queue_depth)
    ) pe_0 (
        .clk        (clk),
        .reset      (reset),
        .din_v      (din_v),
        .din_pe     (din_pe),
        .inst_in_v  (inst_in_v[0]),
        .inst_in    (inst_in[0]),
        .dout_fwd_v (fwd_v),
        .dout_fwd   (fwd),
        .req        (req[0]),
        .gnt        (gnt[0]),
        .res_addr   (addr[0]),
        .res_data   (data[0])
    );

    // last in the chain, forward port left open
    pe #(
        .reg_depth   (reg_depth),
        .queue_depth (queue_depth)
    ) pe_1 (
        .clk        (clk),
        .reset      (reset),
        .din_v      (fwd_v),
        .din_pe     (fwd),
        .inst_in_v  (inst_in_v[1]),
        .inst_in    (inst_in[1]),
        .dout_fwd_v (),
        .dout_fwd   (),
        .req        (req[1]),
        .gnt        (gnt[1]),
        .res_addr   (addr[1]),
        .res_data   (data[1])
    );

    ////////////////////
    // result path
    ////////////////////

    // memory write bus doubles as the result outputs
    result_arbiter #(
        .num_pe (num_pe)
    ) arb (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .addr_in (addr),
        .data_in (data),
        .gnt     (gnt),
        .wr_en   (res_v),
        .wr_addr (res_addr),
        .wr_data (res_data)
    );

    result_mem #(
        .res_depth (res_depth)
    ) mem (
        .clk     (clk),
        .wr_en   (res_v),
        .wr_addr (res_addr),
        .wr_data (res_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

//--- sim/tb_pe_cluster.sv
`timescale 1ns/1ps

module tb_pe_cluster;
    import pe_pkg::*;

    localparam int num_tests = 6;

    logic                clk;
    logic                reset;
    logic                din_v;
    cmplx_t              din_pe;
    logic [1:0]          inst_in_v;
    inst_t [1:0]         inst_in;
    logic                res_v;
    logic [7:0]          res_addr;
    cmplx_t              res_data;
    logic [7:0]          rd_addr;
    cmplx_t              rd_data;

    // model of both register files, fed by the same stream
    cmplx_t      model_reg [2][16];
    int          wp;
    logic [31:0] lfsr;

    // instructions sent in this test, in send order
    inst_t       pend_inst [$];
    int          pend_pe [$];
    // expected memory writes
    int          exp_pe [$];
    logic [7:0]  exp_addr [$];
    cmplx_t      exp_data [$];
    // writes seen on the result bus
    logic [7:0]  seen_addr [$];
    cmplx_t      seen_data [$];

    pe_cluster dut (
        .clk       (clk),
        .reset     (reset),
        .din_v     (din_v),
        .din_pe    (din_pe),
        .inst_in_v (inst_in_v),
        .inst_in   (inst_in),
        .res_v     (res_v),
        .res_addr  (res_addr),
        .res_data  (res_data),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    always #10 clk = ~clk;

    // result bus is stable mid cycle
    always @(negedge clk) begin
        if (!reset && res_v) begin
            seen_addr.push_back(res_addr);
            seen_data.push_back(res_data);
        end
    end

    ////////////////////
    // helpers
    ////////////////////

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_cmplx(input cmplx_t got, input cmplx_t exp, input string what);
        if (got !== exp) begin
            fail_now($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            fail_now($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return r;
    endfunction

    function automatic cmplx_t make_cmplx(input int re, input int im);
        cmplx_t r;
        r.re = re[15:0];
        r.im = im[15:0];
        return r;
    endfunction

    // a times b, or a times conj(b), each part wrapped to 16 bits
    function automatic cmplx_t ref_product(input cmplx_t a, input cmplx_t b, input logic conj);
        longint ar;
        longint ai;
        longint br;
        longint bi;
        longint pr;
        longint pi;
        cmplx_t r;
        ar = a.re;
        ai = a.im;
        br = b.re;
        bi = b.im;
        if (conj) begin
            bi = -bi;
        end
        pr   = ar * br - ai * bi;
        pi   = ar * bi + ai * br;
        r.re = pr[15:0];
        r.im = pi[15:0];
        return r;
    endfunction

    ////////////////////
    // drivers
    ////////////////////

    task automatic start_test();
        reset     = 1'b1;
        din_v     = 1'b0;
        inst_in_v = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        wp    = 0;
        pend_inst.delete();
        pend_pe.delete();
        exp_pe.delete();
        exp_addr.delete();
        exp_data.delete();
        seen_addr.delete();
        seen_data.delete();
    endtask

    task automatic send_operand(input cmplx_t x);
        din_pe = x;
        din_v  = 1'b1;
        // register files fill in stream order and stop when full
        if (wp < 16) begin
            model_reg[0][wp] = x;
            model_reg[1][wp] = x;
            wp++;
        end
        @(negedge clk);
        din_v = 1'b0;
    endtask

    task automatic send_inst(input int pe, input logic [7:0] op, input logic [7:0] a,
                             input logic [7:0] b, input logic [7:0] d);
        inst_t ins;
        ins           = {op, b, a, d};
        inst_in[pe]   = ins;
        inst_in_v[pe] = 1'b1;
        pend_inst.push_back(ins);
        pend_pe.push_back(pe);
        @(negedge clk);
        inst_in_v[pe] = 1'b0;
    endtask

    // run the model, wait for the bus writes, check order and memory
    task automatic finish_test();
        inst_t  ins;
        int     p;
        int     pos [2];
        cmplx_t x;
        foreach (pend_inst[i]) begin
            ins = pend_inst[i];
            p   = pend_pe[i];
            x   = ref_product(model_reg[p][ins.src_a[3:0]], model_reg[p][ins.src_b[3:0]],
                              ins.opcode == op_cmul_conj);
            if (ins.dest[mem_flag]) begin
                exp_pe.push_back(p);
                exp_addr.push_back({1'b0, ins.dest[6:0]});
                exp_data.push_back(x);
            end else begin
                model_reg[p][ins.dest[3:0]] = x;
            end
        end
        while (seen_addr.size() < exp_addr.size()) begin
            @(negedge clk);
        end
        // late extra writes would show up here
        repeat (8) @(negedge clk);
        if (seen_addr.size() != exp_addr.size()) begin
            fail_now($sformatf("wrong number of result writes: saw %0d, expected %0d",
                               seen_addr.size(), exp_addr.size()));
        end
        pos[0] = 0;
        pos[1] = 0;
        foreach (seen_addr[i]) begin
            p = -1;
            foreach (exp_addr[j]) begin
                if (exp_addr[j] == seen_addr[i]) begin
                    p = exp_pe[j];
                end
            end
            if (p < 0) begin
                fail_now($sformatf("result written to unexpected address %h", seen_addr[i]));
            end
            // next expected write of the same element
            while (pos[p] < exp_addr.size() && exp_pe[pos[p]] != p) begin
                pos[p]++;
            end
            if (pos[p] >= exp_addr.size()) begin
                fail_now("an element wrote more results than it was given");
            end
            check_addr(seen_addr[i], exp_addr[pos[p]], "res_addr");
            check_cmplx(seen_data[i], exp_data[pos[p]], "res_data");
            pos[p]++;
        end
        // read port, one cycle latency
        foreach (exp_addr[j]) begin
            rd_addr = exp_addr[j];
            @(negedge clk);
            check_cmplx(rd_data, exp_data[j], "rd_data");
        end
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic reference_example();
        start_test();
        send_inst(0, op_cmul, 0, 1, 8'h80);
        send_inst(0, op_cmul, 2, 3, 8'h81);
        send_inst(0, op_cmul, 4, 5, 8'h82);
        send_operand(make_cmplx(1, 2));
        send_operand(make_cmplx(3, 4));
        send_operand(make_cmplx(5, -6));
        send_operand(make_cmplx(-7, 8));
        send_operand(make_cmplx(100, -200));
        send_operand(make_cmplx(300, 400));
        finish_test();
    endtask

    // parts near full scale so sums wrap
    task automatic conjugate_overflow();
        start_test();
        send_operand(make_cmplx(32767, -32768));
        send_operand(make_cmplx(-32768, 32767));
        send_operand(make_cmplx(30000, 25000));
        send_operand(make_cmplx(-20000, 31000));
        send_inst(1, op_cmul_conj, 0, 1, 8'h80);
        send_inst(1, op_cmul_conj, 2, 3, 8'h81);
        send_inst(1, op_cmul_conj, 1, 2, 8'h82);
        send_inst(1, op_cmul_conj, 0, 0, 8'h83);
        finish_test();
    endtask

    task automatic late_operands();
        start_test();
        send_inst(0, op_cmul, 0, 1, 8'h80);
        send_inst(0, op_cmul_conj, 2, 3, 8'h81);
        send_operand(make_cmplx(1234, -567));
        send_operand(make_cmplx(-890, 4321));
        send_operand(make_cmplx(2222, -3333));
        send_operand(make_cmplx(-4444, 5555));
        send_inst(0, op_cmul, 0, 1, 8'h82);
        send_inst(0, op_cmul_conj, 2, 3, 8'h83);
        // swapped sources, same product
        send_inst(0, op_cmul, 1, 0, 8'h84);
        finish_test();
    endtask

    // queued early so both elements drain back to back
    task automatic both_pe_contention();
        start_test();
        send_inst(0, op_cmul_conj, 4, 5, 8'h80);
        send_inst(1, op_cmul, 5, 4, 8'h88);
        send_inst(0, op_cmul, 0, 1, 8'h81);
        send_inst(1, op_cmul_conj, 3, 2, 8'h89);
        send_inst(0, op_cmul, 2, 3, 8'h82);
        send_inst(1, op_cmul, 0, 5, 8'h8a);
        send_inst(0, op_cmul, 1, 2, 8'h83);
        send_inst(1, op_cmul_conj, 1, 1, 8'h8b);
        for (int i = 0; i < 6; i++) begin
            send_operand(cmplx_t'(rand_bits(32)));
        end
        finish_test();
    endtask

    // registers 10 and 11 are only reached by write-back
    task automatic register_writeback();
        start_test();
        send_operand(make_cmplx(120, -45));
        send_operand(make_cmplx(-33, 78));
        send_operand(make_cmplx(250, 19));
        send_operand(make_cmplx(-7, -310));
        send_inst(0, op_cmul, 0, 1, 8'h0a);
        send_inst(0, op_cmul_conj, 10, 2, 8'h85);
        send_inst(0, op_cmul, 10, 3, 8'h0b);
        send_inst(0, op_cmul, 11, 11, 8'h86);
        finish_test();
    endtask

    task automatic random_regression();
        logic [7:0] op;
        start_test();
        for (int i = 0; i < 8; i++) begin
            send_operand(cmplx_t'(rand_bits(32)));
        end
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 2; p++) begin
                op = rand_bits(1) ? op_cmul_conj : op_cmul;
                send_inst(p, op, 8'(rand_bits(3)), 8'(rand_bits(3)), 8'(8'h80 | (p * 8 + k)));
            end
        end
        finish_test();
    endtask

    ////////////////////
    // run
    ////////////////////

    initial begin
        repeat (num_tests * 200) @(posedge clk);
        fail_now("timeout: tests did not finish in time");
    end

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        din_v     = 1'b0;
        din_pe    = '0;
        inst_in_v = '0;
        inst_in   = '0;
        rd_addr   = '0;
        lfsr      = 32'hb9e8_73d4;
        reference_example();
        conjugate_overflow();
        late_operands();
        both_pe_contention();
        register_writeback();
        random_regression();
        $display("Regression passed");
        $finish;
    end

endmodule

//--- list.f
logic/pe_pkg.sv
logic/cmplx_mult.sv
logic/pe.sv
logic/result_arbiter.sv
logic/result_mem.sv
logic/pe_cluster.sv
sim/tb_pe_cluster.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_pe_cluster -f list.f -o tb_sim
	./obj_dir/tb_sim | tee /dev/stderr | grep -q "Regression passed"

clean:
	rm -rf obj_dir
